// File: src/rt_math_pkg.sv
package rt_math_pkg;

  // Signed Q8.16
  localparam int FX_W = 24;
  localparam int FRAC_BITS = 16;

  typedef logic signed [FX_W-1:0] fx24;

  typedef struct packed {
    fx24 x;
    fx24 y;
    fx24 z;
  } fx24_vec3;

  typedef struct packed {
    fx24 r;
    fx24 g;
    fx24 b;
  } fx24_color;

  localparam fx24 FX_ONE = fx24'(1 << FRAC_BITS);
  localparam fx24 FX_ZERO = '0;
  localparam fx24_color COLOR_ONE = '{r: FX_ONE, g: FX_ONE, b: FX_ONE};
  localparam fx24_color COLOR_ZERO = '{r: FX_ZERO, g: FX_ZERO, b: FX_ZERO};

  // Truncating Q8.16 product
  function automatic fx24 fx_mul(fx24 a, fx24 b);
    logic signed [2*FX_W-1:0] p;
    p = a * b;
    return p[FRAC_BITS +: FX_W];
  endfunction

  function automatic fx24_color fx_color_mul(fx24_color a, fx24_color b);
    fx24_color c;
    c.r = fx_mul(a.r, b.r);
    c.g = fx_mul(a.g, b.g);
    c.b = fx_mul(a.b, b.b);
    return c;
  endfunction

  function automatic fx24_color fx_color_add(fx24_color a, fx24_color b);
    fx24_color c;
    c.r = a.r + b.r;
    c.g = a.g + b.g;
    c.b = a.b + b.b;
    return c;
  endfunction

  // o + t * d per component
  function automatic fx24_vec3 fx_vec_madd(fx24_vec3 o, fx24 t, fx24_vec3 d);
    fx24_vec3 v;
    v.x = o.x + fx_mul(t, d.x);
    v.y = o.y + fx_mul(t, d.y);
    v.z = o.z + fx_mul(t, d.z);
    return v;
  endfunction

endpackage

// File: src/rt_scene_pkg.sv
package rt_scene_pkg;
  import rt_math_pkg::*;

  localparam int SCENE_BUFFER_DEPTH = 8;
  localparam int OBJ_IDX_W = $clog2(SCENE_BUFFER_DEPTH);
  localparam int MAX_BOUNCES = 4;
  localparam int BOUNCE_W = $clog2(MAX_BOUNCES);

  // 1/256, rejects self hits at the bounce origin
  localparam fx24 T_MIN = fx24'(1 << (FRAC_BITS - 8));

  typedef enum logic [1:0] {
    AXIS_X,
    AXIS_Y,
    AXIS_Z
  } axis_t;

  typedef struct packed {
    fx24_color albedo;
    fx24_color emission;
  } material;

  // Axis-aligned plane, normal implied by axis
  typedef struct packed {
    axis_t axis;
    fx24 offset;
    material mat;
  } object;

  typedef struct packed {
    logic [10:0] h;
    logic [9:0] v;
  } pixel_pos;

  typedef struct packed {
    fx24_vec3 pos;
    axis_t axis;
    material mat;
    logic any;
  } hit_info;

  function automatic fx24 vec_get(fx24_vec3 v, axis_t a);
    case (a)
      AXIS_X: return v.x;
      AXIS_Y: return v.y;
      default: return v.z;
    endcase
  endfunction

  function automatic fx24_vec3 vec_set(fx24_vec3 v, axis_t a, fx24 val);
    fx24_vec3 r;
    r = v;
    case (a)
      AXIS_X: r.x = val;
      AXIS_Y: r.y = val;
      default: r.z = val;
    endcase
    return r;
  endfunction

endpackage

// File: src/scene_buffer.sv
`timescale 1ns/1ps

module scene_buffer import rt_scene_pkg::*; (
  input logic clk,
  input logic rst,

  // Load port
  input logic load_en,
  input logic [OBJ_IDX_W-1:0] load_idx,
  input object load_obj,
  input logic load_count_en,
  input logic [OBJ_IDX_W:0] load_count,

  // Read port
  input logic [OBJ_IDX_W-1:0] obj_idx,
  output object obj,
  output logic obj_last,
  output logic scene_empty
);

  object objs [SCENE_BUFFER_DEPTH];
  logic [OBJ_IDX_W:0] count;

  always_ff @(posedge clk) begin
    if (load_en) begin
      objs[load_idx] <= load_obj;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load_count_en) begin
      // Clamp to what the bank can hold
      if (load_count > (OBJ_IDX_W + 1)'(SCENE_BUFFER_DEPTH)) begin
        count <= (OBJ_IDX_W + 1)'(SCENE_BUFFER_DEPTH);
      end else begin
        count <= load_count;
      end
    end
  end

  assign scene_empty = (count == '0);

  // Entries past the count read as an empty object
  always_comb begin
    if ({1'b0, obj_idx} < count) begin
      obj = objs[obj_idx];
    end else begin
      obj = '0;
    end
  end

  assign obj_last = !scene_empty && ({1'b0, obj_idx} == count - 1'b1);

endmodule

// File: src/fx_divider.sv
`timescale 1ns/1ps

module fx_divider import rt_math_pkg::*; (
  input logic clk,
  input logic rst,
  input logic start,
  input fx24 num,
  input fx24 den,
  output logic done,
  output fx24 quot
);

  logic [FX_W-1:0] num_mag;
  logic [FX_W-1:0] den_mag;
  logic [FX_W+FRAC_BITS-1:0] dividend;
  logic [FX_W:0] rem;
  logic [FX_W:0] rem_shift;
  logic [FX_W-1:0] dvd_lo;
  logic [FX_W-1:0] dvs;
  logic [FX_W-1:0] q;
  logic [FX_W-1:0] q_mag;
  logic [4:0] cnt;
  logic running;
  logic neg;
  logic ovf;

  assign num_mag = num[FX_W-1] ? -num : num;
  assign den_mag = den[FX_W-1] ? -den : den;
  assign dividend = {num_mag, FRAC_BITS'(0)};
  assign rem_shift = {rem[FX_W-1:0], dvd_lo[FX_W-1]};

  // Saturate when the quotient does not fit Q8.16
  assign q_mag = (ovf || q[FX_W-1]) ? {1'b0, {(FX_W-1){1'b1}}} : q;

  // 1 load cycle, FX_W shift-subtract steps, 1 sign fix cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      done <= 1'b0;
      cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        rem <= (FX_W + 1)'(dividend[FX_W+FRAC_BITS-1:FX_W]);
        dvd_lo <= dividend[FX_W-1:0];
        dvs <= den_mag;
        neg <= num[FX_W-1] ^ den[FX_W-1];
        ovf <= (dividend[FX_W+FRAC_BITS-1:FX_W] >= den_mag);
        q <= '0;
        cnt <= '0;
        running <= 1'b1;
      end else if (running) begin
        if (cnt == 5'(FX_W)) begin
          quot <= neg ? -q_mag : q_mag;
          done <= 1'b1;
          running <= 1'b0;
        end else begin
          if (rem_shift >= {1'b0, dvs}) begin
            rem <= rem_shift - {1'b0, dvs};
            q <= {q[FX_W-2:0], 1'b1};
          end else begin
            rem <= rem_shift;
            q <= {q[FX_W-2:0], 1'b0};
          end
          dvd_lo <= dvd_lo << 1;
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: src/ray_intersector.sv
`timescale 1ns/1ps

module ray_intersector import rt_math_pkg::*, rt_scene_pkg::*; (
  input logic clk,
  input logic rst,

  input fx24_vec3 ray_origin,
  input fx24_vec3 ray_dir,
  input logic ray_valid,

  // Scene buffer side
  output logic [OBJ_IDX_W-1:0] obj_idx,
  input object obj,
  input logic obj_last,
  input logic scene_empty,

  output hit_info hit,
  output logic hit_valid
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_DIV,
    S_ZERO,
    S_POS,
    S_CMP
  } ix_state_t;

  ix_state_t state;

  object cur_obj;
  logic cur_last;
  fx24 t;
  logic t_ok;
  fx24 best_t;
  fx24_vec3 cand_pos;

  fx24 o_a;
  fx24 d_a;
  logic div_start;
  fx24 div_num;
  fx24 div_den;
  logic div_done;
  fx24 div_quot;

  // Components along the plane axis of the fetched object
  assign o_a = vec_get(ray_origin, obj.axis);
  assign d_a = vec_get(ray_dir, obj.axis);

  assign div_start = (state == S_FETCH) && (d_a != FX_ZERO);
  assign div_num = obj.offset - o_a;
  assign div_den = d_a;

  fx_divider t_div (
    .clk(clk),
    .rst(rst),
    .start(div_start),
    .num(div_num),
    .den(div_den),
    .done(div_done),
    .quot(div_quot)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      hit_valid <= 1'b0;
      obj_idx <= '0;
      hit.any <= 1'b0;
    end else begin
      hit_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (ray_valid) begin
            obj_idx <= '0;
            hit.any <= 1'b0;
            if (scene_empty) begin
              hit_valid <= 1'b1;
            end else begin
              state <= S_FETCH;
            end
          end
        end
        S_FETCH: begin
          cur_obj <= obj;
          cur_last <= obj_last;
          // Parallel ray, no division needed
          state <= (d_a != FX_ZERO) ? S_DIV : S_ZERO;
        end
        S_DIV: begin
          if (div_done) begin
            t <= div_quot;
            t_ok <= (div_quot >= T_MIN);
            state <= S_POS;
          end
        end
        S_ZERO: begin
          t_ok <= 1'b0;
          state <= S_POS;
        end
        S_POS: begin
          // Snap onto the plane to kill rounding drift
          cand_pos <= vec_set(fx_vec_madd(ray_origin, t, ray_dir), cur_obj.axis,
                              cur_obj.offset);
          state <= S_CMP;
        end
        S_CMP: begin
          if (t_ok && (!hit.any || t < best_t)) begin
            hit.pos <= cand_pos;
            hit.axis <= cur_obj.axis;
            hit.mat <= cur_obj.mat;
            hit.any <= 1'b1;
            best_t <= t;
          end
          if (cur_last) begin
            hit_valid <= 1'b1;
            state <= S_IDLE;
          end else begin
            obj_idx <= obj_idx + 1'b1;
            state <= S_FETCH;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: src/ray_reflector.sv
`timescale 1ns/1ps

module ray_reflector import rt_math_pkg::*, rt_scene_pkg::*; (
  input logic clk,
  input logic rst,

  input fx24_vec3 ray_dir,
  input fx24_color ray_color,
  input fx24_color income_light,
  input hit_info hit,
  input logic hit_valid,

  output fx24_vec3 new_dir,
  output fx24_vec3 new_origin,
  output fx24_color new_color,
  output fx24_color new_income_light,
  output logic reflect_done
);

  logic valid_s1;
  fx24_color albedo_prod;
  fx24_color emis_prod;
  fx24_color light_s1;
  fx24_vec3 dir_s1;
  fx24_vec3 pos_s1;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s1 <= 1'b0;
      reflect_done <= 1'b0;
    end else begin
      valid_s1 <= hit_valid;
      reflect_done <= valid_s1;
    end
  end

  // Stage 1 products and mirror direction
  always_ff @(posedge clk) begin
    if (hit_valid) begin
      albedo_prod <= fx_color_mul(ray_color, hit.mat.albedo);
      emis_prod <= fx_color_mul(ray_color, hit.mat.emission);
      light_s1 <= income_light;
      // Plane normal lies on the hit axis, so only that component flips
      dir_s1 <= vec_set(ray_dir, hit.axis, -vec_get(ray_dir, hit.axis));
      pos_s1 <= hit.pos;
    end
  end

  // Stage 2 outputs
  always_ff @(posedge clk) begin
    if (valid_s1) begin
      new_dir <= dir_s1;
      new_origin <= pos_s1;
      new_color <= albedo_prod;
      new_income_light <= fx_color_add(light_s1, emis_prod);
    end
  end

endmodule

// File: src/ray_tracer.sv
`timescale 1ns/1ps

module ray_tracer import rt_math_pkg::*, rt_scene_pkg::*; (
  input logic clk,
  input logic rst,

  input fx24_vec3 ray_origin,
  input fx24_vec3 ray_dir,
  input pixel_pos pix,
  input logic ray_valid,

  output logic busy,
  output logic ray_done,
  output fx24_color pixel_color,
  output pixel_pos pix_out,

  // Scene buffer side
  output logic [OBJ_IDX_W-1:0] obj_idx,
  input object obj,
  input logic obj_last,
  input logic scene_empty
);

  typedef enum logic [1:0] {
    IDLE,
    INTX,
    REFLECT
  } tracer_state_t;

  tracer_state_t state;

  // Current ray and pixel job
  fx24_vec3 cur_origin;
  fx24_vec3 cur_dir;
  fx24_color cur_color;
  fx24_color cur_light;
  pixel_pos cur_pix;
  logic [BOUNCE_W-1:0] bounce_count;

  logic ray_valid_intx;
  logic hit_valid;
  hit_info intx_hit;

  logic hit_valid_rflx;
  logic reflect_done;
  fx24_vec3 rflx_new_dir;
  fx24_vec3 rflx_new_origin;
  fx24_color rflx_new_color;
  fx24_color rflx_new_light;

  assign busy = (state != IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      ray_valid_intx <= 1'b0;
      hit_valid_rflx <= 1'b0;
      ray_done <= 1'b0;
      bounce_count <= '0;
    end else begin
      ray_valid_intx <= 1'b0;
      hit_valid_rflx <= 1'b0;
      ray_done <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            cur_origin <= ray_origin;
            cur_dir <= ray_dir;
            cur_pix <= pix;
            cur_light <= COLOR_ZERO;
            cur_color <= COLOR_ONE;
            bounce_count <= '0;
            ray_valid_intx <= 1'b1;
            state <= INTX;
          end
        end
        INTX: begin
          if (hit_valid) begin
            if (intx_hit.any) begin
              hit_valid_rflx <= 1'b1;
              state <= REFLECT;
            end else begin
              // Escaped the scene
              pixel_color <= cur_light;
              pix_out <= cur_pix;
              ray_done <= 1'b1;
              state <= IDLE;
            end
          end
        end
        REFLECT: begin
          if (reflect_done) begin
            cur_dir <= rflx_new_dir;
            cur_origin <= rflx_new_origin;
            cur_color <= rflx_new_color;
            cur_light <= rflx_new_light;
            if (bounce_count == BOUNCE_W'(MAX_BOUNCES - 1)) begin
              pixel_color <= rflx_new_light;
              pix_out <= cur_pix;
              ray_done <= 1'b1;
              state <= IDLE;
            end else begin
              bounce_count <= bounce_count + 1'b1;
              ray_valid_intx <= 1'b1;
              state <= INTX;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ray_intersector ray_intx (
    .clk(clk),
    .rst(rst),
    .ray_origin(cur_origin),
    .ray_dir(cur_dir),
    .ray_valid(ray_valid_intx),
    .obj_idx(obj_idx),
    .obj(obj),
    .obj_last(obj_last),
    .scene_empty(scene_empty),
    .hit(intx_hit),
    .hit_valid(hit_valid)
  );

  ray_reflector ray_rflx (
    .clk(clk),
    .rst(rst),
    .ray_dir(cur_dir),
    .ray_color(cur_color),
    .income_light(cur_light),
    .hit(intx_hit),
    .hit_valid(hit_valid_rflx),
    .new_dir(rflx_new_dir),
    .new_origin(rflx_new_origin),
    .new_color(rflx_new_color),
    .new_income_light(rflx_new_light),
    .reflect_done(reflect_done)
  );

endmodule

// File: src/pixel_tracer_top.sv
`timescale 1ns/1ps

module pixel_tracer_top import rt_math_pkg::*, rt_scene_pkg::*; (
  input logic clk,
  input logic rst,

  // Scene loading
  input logic load_en,
  input logic [OBJ_IDX_W-1:0] load_idx,
  input object load_obj,
  input logic load_count_en,
  input logic [OBJ_IDX_W:0] load_count,

  // Ray submission
  input fx24_vec3 ray_origin,
  input fx24_vec3 ray_dir,
  input pixel_pos pix,
  input logic ray_valid,

  output logic busy,
  output logic ray_done,
  output fx24_color pixel_color,
  output pixel_pos pix_out
);

  logic [OBJ_IDX_W-1:0] obj_idx;
  object obj;
  logic obj_last;
  logic scene_empty;

  ray_tracer tracer (
    .clk(clk),
    .rst(rst),
    .ray_origin(ray_origin),
    .ray_dir(ray_dir),
    .pix(pix),
    .ray_valid(ray_valid),
    .busy(busy),
    .ray_done(ray_done),
    .pixel_color(pixel_color),
    .pix_out(pix_out),
    .obj_idx(obj_idx),
    .obj(obj),
    .obj_last(obj_last),
    .scene_empty(scene_empty)
  );

  scene_buffer scene (
    .clk(clk),
    .rst(rst),
    .load_en(load_en),
    .load_idx(load_idx),
    .load_obj(load_obj),
    .load_count_en(load_count_en),
    .load_count(load_count),
    .obj_idx(obj_idx),
    .obj(obj),
    .obj_last(obj_last),
    .scene_empty(scene_empty)
  );

endmodule

// File: dv/tracer_asserts.sv
`timescale 1ns/1ps

module tracer_asserts import rt_math_pkg::*, rt_scene_pkg::*; (
  input logic clk,
  input logic rst,
  input logic ray_valid,
  input pixel_pos pix,
  input logic busy,
  input logic ray_done,
  input pixel_pos pix_out,
  input logic [OBJ_IDX_W-1:0] obj_idx,
  input logic obj_last,
  input fx24_vec3 cur_dir,
  input hit_info intx_hit,
  input logic reflect_done,
  input fx24_vec3 rflx_new_dir
);

  pixel_pos accepted_pix;
  logic mirror_ok;

  // Pixel of the ray the tracer took
  always_ff @(posedge clk) begin
    if (ray_valid && !busy) begin
      accepted_pix <= pix;
    end
  end

  // Only the hit axis component flips
  always_comb begin
    case (intx_hit.axis)
      AXIS_X: mirror_ok = (rflx_new_dir.x == -cur_dir.x) && (rflx_new_dir.y == cur_dir.y) &&
                          (rflx_new_dir.z == cur_dir.z);
      AXIS_Y: mirror_ok = (rflx_new_dir.x == cur_dir.x) && (rflx_new_dir.y == -cur_dir.y) &&
                          (rflx_new_dir.z == cur_dir.z);
      default: mirror_ok = (rflx_new_dir.x == cur_dir.x) && (rflx_new_dir.y == cur_dir.y) &&
                           (rflx_new_dir.z == -cur_dir.z);
    endcase
  end

  reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !ray_done && !busy)
    else $error("ray_done or busy high in the cycle after reset");

  pix_matches: assert property (@(posedge clk) disable iff (rst)
    ray_done |-> pix_out == accepted_pix)
    else $error("pix_out differs from the pixel of the accepted ray");

  done_single: assert property (@(posedge clk) disable iff (rst) ray_done |=> !ray_done)
    else $error("ray_done held for more than one cycle");

  mirror_rule: assert property (@(posedge clk) disable iff (rst) reflect_done |-> mirror_ok)
    else $error("reflected direction breaks the mirror rule");

  // Index never steps past the last loaded object
  idx_in_range: assert property (@(posedge clk) disable iff (rst)
    (obj_idx != $past(obj_idx)) && (obj_idx != '0) |-> !$past(obj_last))
    else $error("obj_idx advanced beyond the loaded object count");

  busy_on_accept: assert property (@(posedge clk) disable iff (rst)
    ray_valid && !busy |=> busy)
    else $error("busy not raised after a ray was accepted");

  busy_until_done: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> ray_done)
    else $error("busy dropped without ray_done");

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import rt_math_pkg::*, rt_scene_pkg::*; ();

  localparam logic [31:0] SEED = 32'ha12557b5;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RANDOM_RAYS = 6;
  localparam fx24 HALF = fx24'(1 << (FRAC_BITS - 1));
  localparam fx24 QUARTER = fx24'(1 << (FRAC_BITS - 2));
  localparam fx24_color WALL_EMISSION = '{r: HALF, g: QUARTER, b: FX_ONE};
  localparam fx24_color HALF_ALBEDO = '{r: HALF, g: HALF, b: HALF};
  localparam fx24_color DECOY_EMISSION = '{r: FX_ONE, g: FX_ONE, b: FX_ONE};

  logic clk;
  logic rst;
  logic load_en;
  logic [OBJ_IDX_W-1:0] load_idx;
  object load_obj;
  logic load_count_en;
  logic [OBJ_IDX_W:0] load_count;
  fx24_vec3 ray_origin;
  fx24_vec3 ray_dir;
  pixel_pos pix;
  logic ray_valid;
  logic busy;
  logic ray_done;
  fx24_color pixel_color;
  pixel_pos pix_out;

  integer seed;
  int done_count;

  pixel_tracer_top dut (
    .clk(clk),
    .rst(rst),
    .load_en(load_en),
    .load_idx(load_idx),
    .load_obj(load_obj),
    .load_count_en(load_count_en),
    .load_count(load_count),
    .ray_origin(ray_origin),
    .ray_dir(ray_dir),
    .pix(pix),
    .ray_valid(ray_valid),
    .busy(busy),
    .ray_done(ray_done),
    .pixel_color(pixel_color),
    .pix_out(pix_out)
  );

  bind ray_tracer tracer_asserts asserts (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .pix(pix),
    .busy(busy),
    .ray_done(ray_done),
    .pix_out(pix_out),
    .obj_idx(obj_idx),
    .obj_last(obj_last),
    .cur_dir(cur_dir),
    .intx_hit(intx_hit),
    .reflect_done(reflect_done),
    .rflx_new_dir(rflx_new_dir)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Count ray_done pulses on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      done_count <= 0;
    end else if (ray_done) begin
      done_count <= done_count + 1;
    end
  end

  function automatic fx24 to_fx(input int n);
    return fx24'(n * (1 << FRAC_BITS));
  endfunction

  // Light after a run of bounces off walls of one albedo and emission
  function automatic fx24_color expected_light(input fx24_color emission, input real albedo,
                                               input int bounces);
    real weight;
    real total;
    fx24_color c;
    weight = 1.0;
    total = 0.0;
    for (int k = 0; k < bounces; k++) begin
      total = total + weight;
      weight = weight * albedo;
    end
    c.r = fx24'($rtoi($itor(emission.r) * total));
    c.g = fx24'($rtoi($itor(emission.g) * total));
    c.b = fx24'($rtoi($itor(emission.b) * total));
    return c;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input longint got, input longint exp, input string what);
    assert (got == exp) else begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_color(input fx24_color got, input fx24_color exp, input string what);
    assert (got == exp) else begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s color %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic load_plane(input int idx, input axis_t axis, input fx24 offset,
                            input fx24_color albedo, input fx24_color emission);
    @(negedge clk);
    load_en = 1'b1;
    load_idx = OBJ_IDX_W'(idx);
    load_obj.axis = axis;
    load_obj.offset = offset;
    load_obj.mat.albedo = albedo;
    load_obj.mat.emission = emission;
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic set_count(input int n);
    @(negedge clk);
    load_count_en = 1'b1;
    load_count = (OBJ_IDX_W + 1)'(n);
    @(negedge clk);
    load_count_en = 1'b0;
  endtask

  task automatic submit_ray(input fx24_vec3 origin, input fx24_vec3 dir, input pixel_pos p);
    @(negedge clk);
    ray_valid = 1'b1;
    ray_origin = origin;
    ray_dir = dir;
    pix = p;
    @(negedge clk);
    ray_valid = 1'b0;
  endtask

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    while (!ray_done) begin
      if (cycles >= TIMEOUT_CYCLES) begin
        stop_with_failure("Timeout: the DUT never raised ray_done");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic trace_and_check(input fx24_vec3 origin, input fx24_vec3 dir,
                                 input pixel_pos p, input fx24_color exp, input string what);
    submit_ray(origin, dir, p);
    wait_for_done();
    check_color(pixel_color, exp, what);
    check_value(pix_out, p, {what, " pix_out"});
  endtask

  initial begin
    pixel_pos fixed_pix;
    pixel_pos rand_pix;
    fx24_vec3 origin;
    fx24_vec3 dir;
    int start_count;

    seed = SEED;
    rst = 1'b1;
    load_en = 1'b0;
    load_idx = '0;
    load_obj = '0;
    load_count_en = 1'b0;
    load_count = '0;
    ray_origin = '0;
    ray_dir = '0;
    pix = '0;
    ray_valid = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    repeat (4) begin
      @(negedge clk);
      check_value(busy, 0, "busy after reset");
      check_value(ray_done, 0, "ray_done after reset");
    end

    // Empty scene lets the ray escape at once
    fixed_pix = '{h: 11'd17, v: 10'd5};
    origin = '{x: FX_ZERO, y: FX_ZERO, z: FX_ZERO};
    dir = '{x: FX_ONE, y: FX_ZERO, z: FX_ZERO};
    set_count(0);
    trace_and_check(origin, dir, fixed_pix, COLOR_ZERO, "empty scene");

    // One emissive wall ahead
    load_plane(0, AXIS_X, to_fx(4), COLOR_ONE, WALL_EMISSION);
    set_count(1);
    fixed_pix = '{h: 11'd640, v: 10'd480};
    trace_and_check(origin, dir, fixed_pix, expected_light(WALL_EMISSION, 1.0, 1),
                    "single wall");

    // Two facing walls with a decoy behind the near one
    load_plane(0, AXIS_X, to_fx(6), COLOR_ONE, DECOY_EMISSION);
    load_plane(1, AXIS_X, to_fx(2), HALF_ALBEDO, WALL_EMISSION);
    load_plane(2, AXIS_X, to_fx(-2), HALF_ALBEDO, WALL_EMISSION);
    set_count(3);
    origin = '{x: FX_ZERO, y: HALF, z: -FX_ONE};
    dir = '{x: FX_ONE, y: QUARTER, z: -(QUARTER >>> 1)};
    fixed_pix = '{h: 11'd1919, v: 10'd1023};
    trace_and_check(origin, dir, fixed_pix,
                    expected_light(WALL_EMISSION, 0.5, MAX_BOUNCES), "facing walls");

    // Random pixels with a dropped request while busy
    for (int n = 0; n < RANDOM_RAYS; n++) begin
      rand_pix.h = 11'($random(seed));
      rand_pix.v = 10'($random(seed));
      dir.x = ($random(seed) & 1) ? FX_ONE : -FX_ONE;
      submit_ray(origin, dir, rand_pix);
      start_count = done_count;
      repeat (3) @(negedge clk);
      check_value(busy, 1, "busy with a ray in flight");
      submit_ray(origin, dir, ~rand_pix);
      wait_for_done();
      check_color(pixel_color, expected_light(WALL_EMISSION, 0.5, MAX_BOUNCES), "random ray");
      check_value(pix_out, rand_pix, "random ray pix_out");
      repeat (4) @(negedge clk);
      check_value(done_count, start_count + 1, "ray_done count per accepted ray");
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// File: compile.f
src/rt_math_pkg.sv
src/rt_scene_pkg.sv
src/scene_buffer.sv
src/fx_divider.sv
src/ray_intersector.sv
src/ray_reflector.sv
src/ray_tracer.sv
src/pixel_tracer_top.sv
dv/tracer_asserts.sv
dv/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, exit status follows the simulation
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f &&
  ./obj_dir/Vtb_top ||
  { echo "Simulation did not complete cleanly"; exit 1; }
